/* Makefile */
TOP := tb_bud

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

/* axi_block_ram.sv */
module axi_block_ram
(
   input  logic                    clk_main_a0,
   input  logic                    rst_main_n,

   // Write address and data, accepted together
   input  logic                    mem_awvalid,
   input  bud_map_pkg::mem_index_t mem_awindex,
   output logic                    mem_awready,
   input  logic                    mem_wvalid,
   input  bud_map_pkg::mem_word_t  mem_wdata,
   input  bud_map_pkg::mem_strb_t  mem_wstrb,
   output logic                    mem_wready,

   // Write response
   output logic                    mem_bvalid,
   input  logic                    mem_bready,

   // Read address
   input  logic                    mem_arvalid,
   input  bud_map_pkg::mem_index_t mem_arindex,
   output logic                    mem_arready,

   // Read data
   output logic                    mem_rvalid,
   output bud_map_pkg::mem_word_t  mem_rdata,
   input  logic                    mem_rready
);

   import bud_map_pkg::*;

   mem_word_t  mem [MEM_DEPTH];

   logic       scrub_busy;
   mem_index_t scrub_idx;

   logic       idle_ready;
   logic       wr_fire;
   logic       rd_fire;

   // ----------------------------------------
   // Handshakes
   // ----------------------------------------
   // Busy while scrubbing or while a response waits to be taken
   assign idle_ready = !scrub_busy && !mem_bvalid && !mem_rvalid;

   assign mem_awready = idle_ready;
   assign mem_wready  = idle_ready;

   // Write wins when both arrive in one cycle
   assign mem_arready = idle_ready && !(mem_awvalid && mem_wvalid);

   assign wr_fire = mem_awvalid && mem_wvalid && idle_ready;
   assign rd_fire = mem_arvalid && mem_arready;

   // ----------------------------------------
   // Scrub counter and response flags
   // ----------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n)
      begin
         scrub_busy <= 1'b1;
         scrub_idx  <= '0;
         mem_bvalid <= 1'b0;
         mem_rvalid <= 1'b0;
      end
      else
      begin
         // One word per cycle, last word ends the scrub
         if (scrub_busy)
         begin
            scrub_idx <= scrub_idx + 1'b1;
            if (scrub_idx == mem_index_t'(MEM_DEPTH - 1))
               scrub_busy <= 1'b0;
         end

         if (wr_fire)
            mem_bvalid <= 1'b1;
         else if (mem_bready)
            mem_bvalid <= 1'b0;

         if (rd_fire)
            mem_rvalid <= 1'b1;
         else if (mem_rready)
            mem_rvalid <= 1'b0;
      end
   end

   // ----------------------------------------
   // Storage
   // ----------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (scrub_busy)
      begin
         mem[scrub_idx] <= '0;
      end
      else if (wr_fire)
      begin
         // Byte merge under the strobes
         for (int i = 0; i < MEM_STRB_W; i++)
         begin
            if (mem_wstrb[i])
               mem[mem_awindex][i*8 +: 8] <= mem_wdata[i*8 +: 8];
         end
      end
   end

   // Read data stays put until the next read
   always_ff @(posedge clk_main_a0)
   begin
      if (rd_fire)
         mem_rdata <= mem[mem_arindex];
   end

endmodule

/* axil_to_axi_bridge.sv */
module axil_to_axi_bridge
(
   input  logic                    clk_main_a0,
   input  logic                    rst_main_n,

   // Lite write address
   input  logic                    awvalid,
   input  bud_axi_pkg::lite_addr_t awaddr,
   output logic                    awready,

   // Lite write data
   input  logic                    wvalid,
   input  bud_axi_pkg::lite_data_t wdata,
   input  bud_axi_pkg::lite_strb_t wstrb,
   output logic                    wready,

   // Lite write response
   output logic                    bvalid,
   output bud_axi_pkg::resp_t      bresp,
   input  logic                    bready,

   // Lite read address
   input  logic                    arvalid,
   input  bud_axi_pkg::lite_addr_t araddr,
   output logic                    arready,

   // Lite read data
   output logic                    rvalid,
   output bud_axi_pkg::lite_data_t rdata,
   output bud_axi_pkg::resp_t      rresp,
   input  logic                    rready,

   // Memory write channels
   output logic                    mem_awvalid,
   output bud_map_pkg::mem_index_t mem_awindex,
   input  logic                    mem_awready,
   output logic                    mem_wvalid,
   output bud_map_pkg::mem_word_t  mem_wdata,
   output bud_map_pkg::mem_strb_t  mem_wstrb,
   input  logic                    mem_wready,
   input  logic                    mem_bvalid,
   output logic                    mem_bready,

   // Memory read channels
   output logic                    mem_arvalid,
   output bud_map_pkg::mem_index_t mem_arindex,
   input  logic                    mem_arready,
   input  logic                    mem_rvalid,
   input  bud_map_pkg::mem_word_t  mem_rdata,
   output logic                    mem_rready
);

   import bud_axi_pkg::*;
   import bud_map_pkg::*;

   bridge_state_t state;

   // Memory request still waiting for its handshake
   logic          mem_req_q;

   logic          upper_q;
   mem_index_t    index_q;
   mem_word_t     wdata_q;
   mem_strb_t     wstrb_q;
   resp_t         resp_q;
   lite_data_t    rdata_q;

   logic          wr_accept;
   logic          rd_accept;
   logic          wr_in_mem;
   logic          rd_in_mem;
   logic          rd_is_version;
   logic          mem_wr_fire;
   logic          mem_rd_fire;
   logic          mem_wr_done;
   logic          mem_rd_done;

   // ----------------------------------------
   // Lite acceptance and decode
   // ----------------------------------------
   // Readies follow the RAM, so nothing is taken during the scrub
   assign wr_accept = (state == IDLE) && awvalid && wvalid && mem_awready;

   // A write that is only half presented still blocks reads
   assign rd_accept = (state == IDLE) && arvalid && !awvalid && !wvalid && mem_arready;

   assign awready = wr_accept;
   assign wready  = wr_accept;
   assign arready = rd_accept;

   assign wr_in_mem     = awaddr < lite_addr_t'(MEM_BYTES);
   assign rd_in_mem     = araddr < lite_addr_t'(MEM_BYTES);
   assign rd_is_version = araddr == VERSION_ADDR;

   // ----------------------------------------
   // Memory port
   // ----------------------------------------
   assign mem_awvalid = (state == MEM_WRITE) && mem_req_q;
   assign mem_wvalid  = mem_awvalid;
   assign mem_awindex = index_q;
   assign mem_wdata   = wdata_q;
   assign mem_wstrb   = wstrb_q;
   assign mem_bready  = (state == MEM_WRITE) && !mem_req_q;

   assign mem_arvalid = (state == MEM_READ) && mem_req_q;
   assign mem_arindex = index_q;
   assign mem_rready  = (state == MEM_READ) && !mem_req_q;

   assign mem_wr_fire = mem_awvalid && mem_awready && mem_wready;
   assign mem_rd_fire = mem_arvalid && mem_arready;
   assign mem_wr_done = mem_bvalid && mem_bready;
   assign mem_rd_done = mem_rvalid && mem_rready;

   // Lite responses come straight from the FSM and payload registers
   assign bvalid = state == WRITE_RESP;
   assign rvalid = state == READ_RESP;
   assign bresp  = resp_q;
   assign rresp  = resp_q;
   assign rdata  = rdata_q;

   // ----------------------------------------
   // FSM
   // ----------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n)
      begin
         state     <= IDLE;
         mem_req_q <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               // Decoded errors and the version read skip the RAM
               if (wr_accept)
               begin
                  state     <= wr_in_mem ? MEM_WRITE : WRITE_RESP;
                  mem_req_q <= wr_in_mem;
               end
               else if (rd_accept)
               begin
                  state     <= rd_in_mem ? MEM_READ : READ_RESP;
                  mem_req_q <= rd_in_mem;
               end
            end
            MEM_WRITE:
            begin
               if (mem_wr_fire)
                  mem_req_q <= 1'b0;
               if (mem_wr_done)
                  state <= WRITE_RESP;
            end
            MEM_READ:
            begin
               if (mem_rd_fire)
                  mem_req_q <= 1'b0;
               if (mem_rd_done)
                  state <= READ_RESP;
            end
            WRITE_RESP:
            begin
               if (bready)
                  state <= IDLE;
            end
            READ_RESP:
            begin
               if (rready)
                  state <= IDLE;
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------
   // Request and response payload
   // ----------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (wr_accept)
      begin
         index_q <= mem_index_t'(awaddr >> 3);
         // Data goes on both lanes, strobes pick the live one
         wdata_q <= {wdata, wdata};
         wstrb_q <= awaddr[2] ? {wstrb, lite_strb_t'(0)} : {lite_strb_t'(0), wstrb};
         resp_q  <= wr_in_mem ? OKAY : SLVERR;
      end
      else if (rd_accept)
      begin
         index_q <= mem_index_t'(araddr >> 3);
         upper_q <= araddr[2];
         resp_q  <= (rd_in_mem || rd_is_version) ? OKAY : SLVERR;
         rdata_q <= rd_is_version ? BUD_VERSION : '0;
      end
      else if (mem_rd_done)
      begin
         rdata_q <= upper_q ? mem_rdata[63:32] : mem_rdata[31:0];
      end
   end

endmodule

/* bud_axi_pkg.sv */
package bud_axi_pkg;

   // ----------------------------------------
   // Lite bus widths
   // ----------------------------------------
   localparam int LITE_ADDR_W = 32;
   localparam int LITE_DATA_W = 32;
   localparam int LITE_STRB_W = LITE_DATA_W / 8;

   // Byte address as seen on the host register bus
   typedef logic [LITE_ADDR_W-1:0] lite_addr_t;

   // Register data, one 32-bit half of a memory word
   typedef logic [LITE_DATA_W-1:0] lite_data_t;

   // One strobe per data byte
   typedef logic [LITE_STRB_W-1:0] lite_strb_t;

   // ----------------------------------------
   // Response codes
   // ----------------------------------------
   typedef enum logic [1:0]
   {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } resp_t;

   // ----------------------------------------
   // Bridge FSM
   // ----------------------------------------
   typedef enum logic [2:0]
   {
      IDLE,
      MEM_WRITE,
      MEM_READ,
      WRITE_RESP,
      READ_RESP
   } bridge_state_t;

endpackage

/* bud_checker.sv */
module bud_checker
(
   input logic        clk_main_a0,
   input logic        rst_main_n,
   input logic        awready,
   input logic        wready,
   input logic        arready,
   input logic        bvalid,
   input logic        bready,
   input logic [1:0]  bresp,
   input logic        rvalid,
   input logic        rready,
   input logic [31:0] rdata,
   input logic [1:0]  rresp
);

   // ----------------------------------------
   // Response hold under back-pressure
   // ----------------------------------------
   assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid or bresp changed before bready");

   assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("rvalid, rdata or rresp changed before rready");

   // ----------------------------------------
   // Write acceptance and reset state
   // ----------------------------------------
   // Write response one cycle after a decoded error, three after a RAM write
   assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
      $rose(bvalid) |-> $past(awready && wready, 1) || $past(awready && wready, 3))
      else $error("bvalid rose without a write accepted one or three cycles before");

   // RAM is still scrubbing right after reset
   assert property (@(posedge clk_main_a0)
      !rst_main_n |=> !awready && !wready && !arready && !bvalid && !rvalid)
      else $error("Lite handshake active in the cycle after reset");

endmodule

/* bud_map_pkg.sv */
package bud_map_pkg;

   // ----------------------------------------
   // Memory geometry
   // ----------------------------------------
   localparam int MEM_WORD_W  = 64;
   localparam int MEM_STRB_W  = MEM_WORD_W / 8;
   localparam int MEM_DEPTH   = 1024;
   localparam int MEM_INDEX_W = $clog2(MEM_DEPTH);

   // Word index into the block RAM
   typedef logic [MEM_INDEX_W-1:0] mem_index_t;

   // One full RAM word, two Lite lanes wide
   typedef logic [MEM_WORD_W-1:0] mem_word_t;

   // Byte strobes for a full word
   typedef logic [MEM_STRB_W-1:0] mem_strb_t;

   // ----------------------------------------
   // Host address map
   // ----------------------------------------
   // RAM window starts at byte zero
   localparam int MEM_BYTES = MEM_DEPTH * MEM_STRB_W;

   // Read-only status register just past the RAM
   localparam logic [31:0] VERSION_ADDR = 32'h0000_2000;

   // Design version returned by the status register
   localparam logic [31:0] BUD_VERSION = 32'hEEEE_EE00;

endpackage

/* bud_top.sv */
module bud_top
(
   input  logic                    clk_main_a0,
   input  logic                    rst_main_n,

   // Host write channels
   input  logic                    awvalid,
   input  bud_axi_pkg::lite_addr_t awaddr,
   output logic                    awready,
   input  logic                    wvalid,
   input  bud_axi_pkg::lite_data_t wdata,
   input  bud_axi_pkg::lite_strb_t wstrb,
   output logic                    wready,
   output logic                    bvalid,
   output bud_axi_pkg::resp_t      bresp,
   input  logic                    bready,

   // Host read channels
   input  logic                    arvalid,
   input  bud_axi_pkg::lite_addr_t araddr,
   output logic                    arready,
   output logic                    rvalid,
   output bud_axi_pkg::lite_data_t rdata,
   output bud_axi_pkg::resp_t      rresp,
   input  logic                    rready
);

   import bud_map_pkg::*;

   // ----------------------------------------
   // Memory port between bridge and RAM
   // ----------------------------------------
   logic       mem_awvalid;
   mem_index_t mem_awindex;
   logic       mem_awready;
   logic       mem_wvalid;
   mem_word_t  mem_wdata;
   mem_strb_t  mem_wstrb;
   logic       mem_wready;
   logic       mem_bvalid;
   logic       mem_bready;
   logic       mem_arvalid;
   mem_index_t mem_arindex;
   logic       mem_arready;
   logic       mem_rvalid;
   mem_word_t  mem_rdata;
   logic       mem_rready;

   // Lite to 64-bit memory conversion
   axil_to_axi_bridge bridge
   (
      .clk_main_a0 (clk_main_a0),
      .rst_main_n  (rst_main_n),
      .awvalid     (awvalid),
      .awaddr      (awaddr),
      .awready     (awready),
      .wvalid      (wvalid),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wready      (wready),
      .bvalid      (bvalid),
      .bresp       (bresp),
      .bready      (bready),
      .arvalid     (arvalid),
      .araddr      (araddr),
      .arready     (arready),
      .rvalid      (rvalid),
      .rdata       (rdata),
      .rresp       (rresp),
      .rready      (rready),
      .mem_awvalid (mem_awvalid),
      .mem_awindex (mem_awindex),
      .mem_awready (mem_awready),
      .mem_wvalid  (mem_wvalid),
      .mem_wdata   (mem_wdata),
      .mem_wstrb   (mem_wstrb),
      .mem_wready  (mem_wready),
      .mem_bvalid  (mem_bvalid),
      .mem_bready  (mem_bready),
      .mem_arvalid (mem_arvalid),
      .mem_arindex (mem_arindex),
      .mem_arready (mem_arready),
      .mem_rvalid  (mem_rvalid),
      .mem_rdata   (mem_rdata),
      .mem_rready  (mem_rready)
   );

   // Scrubbed block RAM
   axi_block_ram smem
   (
      .clk_main_a0 (clk_main_a0),
      .rst_main_n  (rst_main_n),
      .mem_awvalid (mem_awvalid),
      .mem_awindex (mem_awindex),
      .mem_awready (mem_awready),
      .mem_wvalid  (mem_wvalid),
      .mem_wdata   (mem_wdata),
      .mem_wstrb   (mem_wstrb),
      .mem_wready  (mem_wready),
      .mem_bvalid  (mem_bvalid),
      .mem_bready  (mem_bready),
      .mem_arvalid (mem_arvalid),
      .mem_arindex (mem_arindex),
      .mem_arready (mem_arready),
      .mem_rvalid  (mem_rvalid),
      .mem_rdata   (mem_rdata),
      .mem_rready  (mem_rready)
   );

endmodule

/* sim.f */
bud_axi_pkg.sv
bud_map_pkg.sv
axil_to_axi_bridge.sv
axi_block_ram.sv
bud_top.sv
tb_clock.sv
bud_checker.sv
tb_bud.sv

/* tb_bud.sv */
module tb_bud;

   localparam int          WAIT_LIMIT  = 2000;
   localparam logic [31:0] RAM_LIMIT   = 32'h0000_2000;
   localparam logic [31:0] VERSION_REG = 32'h0000_2000;
   localparam logic [31:0] VERSION_VAL = 32'hEEEE_EE00;
   localparam logic [1:0]  RESP_OKAY   = 2'b00;
   localparam logic [1:0]  RESP_SLVERR = 2'b10;

   logic        clk_main_a0;
   logic        rst_main_n;
   logic        awvalid;
   logic [31:0] awaddr;
   logic        awready;
   logic        wvalid;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wready;
   logic        bvalid;
   logic [1:0]  bresp;
   logic        bready;
   logic        arvalid;
   logic [31:0] araddr;
   logic        arready;
   logic        rvalid;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rready;

   // Reference model, one entry per Lite word of the RAM window
   logic [31:0] model [2048];

   logic [15:0] lfsr = 16'd48;
   int          errors;
   int          checks;
   int          tests;
   int          tests_failed;
   int          errors_at_start;
   int          issued;
   int          completed;
   logic        b_pending;
   logic        r_pending;

   tb_clock u_clock
   (
      .clk_main_a0 (clk_main_a0)
   );

   bud_top i_bud_top
   (
      .clk_main_a0 (clk_main_a0),
      .rst_main_n  (rst_main_n),
      .awvalid     (awvalid),
      .awaddr      (awaddr),
      .awready     (awready),
      .wvalid      (wvalid),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wready      (wready),
      .bvalid      (bvalid),
      .bresp       (bresp),
      .bready      (bready),
      .arvalid     (arvalid),
      .araddr      (araddr),
      .arready     (arready),
      .rvalid      (rvalid),
      .rdata       (rdata),
      .rresp       (rresp),
      .rready      (rready)
   );

   bind axil_to_axi_bridge bud_checker u_checker
   (
      .clk_main_a0 (clk_main_a0),
      .rst_main_n  (rst_main_n),
      .awready     (awready),
      .wready      (wready),
      .arready     (arready),
      .bvalid      (bvalid),
      .bready      (bready),
      .bresp       (bresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .rdata       (rdata),
      .rresp       (rresp)
   );

   // Count each new Lite response offered by the DUT
   always @(posedge clk_main_a0)
   begin
      if (!rst_main_n)
      begin
         completed <= 0;
         b_pending <= 1'b0;
         r_pending <= 1'b0;
      end
      else
      begin
         completed <= completed + int'(bvalid && !b_pending) + int'(rvalid && !r_pending);
         b_pending <= bvalid && !bready;
         r_pending <= rvalid && !rready;
      end
   end

   // ----------------------------------------
   // Random numbers and model helpers
   // ----------------------------------------
   // 16-bit Fibonacci LFSR, taps 16 15 13 4
   function automatic logic [31:0] rand_bits(input int count);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         value = {value[30:0], lfsr[15]};
         fb    = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
         lfsr  = {lfsr[14:0], fb};
      end
      return value;
   endfunction

   function automatic logic [31:0] ram_addr();
      return rand_bits(11) << 2;
   endfunction

   // Somewhere past the version register
   function automatic logic [31:0] high_addr();
      logic [31:0] a;
      a = rand_bits(30) << 2;
      if (a <= VERSION_REG)
         a = a + 32'h0000_4000;
      return a;
   endfunction

   function automatic logic [31:0] merge_bytes
   (
      input logic [31:0] old,
      input logic [31:0] data,
      input logic [3:0]  strb
   );
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            res[b*8 +: 8] = data[b*8 +: 8];
      end
      return res;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic abort_run(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("=== FAIL ===");
      $finish;
   endtask

   // ----------------------------------------
   // Lite transactions
   // ----------------------------------------
   task automatic lite_write
   (
      input  logic [31:0] addr,
      input  logic [31:0] data,
      input  logic [3:0]  strb,
      input  int          delay,
      output logic [1:0]  resp
   );
      int   n;
      logic seen;
      awvalid <= 1'b1;
      awaddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      issued++;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_LIMIT)
      begin
         @(posedge clk_main_a0);
         seen = awready && wready;
         n++;
      end
      if (!seen)
         abort_run("the write address and data were never accepted");
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      // Hold bready low for a while, the response must wait
      repeat (delay) @(posedge clk_main_a0);
      bready <= 1'b1;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_LIMIT)
      begin
         @(posedge clk_main_a0);
         seen = bvalid;
         n++;
      end
      if (!seen)
         abort_run("no write response arrived");
      resp = bresp;
      bready <= 1'b0;
   endtask

   task automatic lite_read
   (
      input  logic [31:0] addr,
      input  int          delay,
      output logic [31:0] data,
      output logic [1:0]  resp
   );
      int   n;
      logic seen;
      arvalid <= 1'b1;
      araddr  <= addr;
      issued++;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_LIMIT)
      begin
         @(posedge clk_main_a0);
         seen = arready;
         n++;
      end
      if (!seen)
         abort_run("the read address was never accepted");
      arvalid <= 1'b0;
      repeat (delay) @(posedge clk_main_a0);
      rready <= 1'b1;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_LIMIT)
      begin
         @(posedge clk_main_a0);
         seen = rvalid;
         n++;
      end
      if (!seen)
         abort_run("no read data arrived");
      data = rdata;
      resp = rresp;
      rready <= 1'b0;
   endtask

   task automatic write_and_check
   (
      input logic [31:0] addr,
      input logic [31:0] data,
      input logic [3:0]  strb,
      input int          delay
   );
      logic [1:0] resp;
      logic [1:0] exp_resp;
      exp_resp = (addr < RAM_LIMIT) ? RESP_OKAY : RESP_SLVERR;
      lite_write(addr, data, strb, delay, resp);
      check_value({30'd0, resp}, {30'd0, exp_resp}, $sformatf("bresp of write to %h", addr));
      // Only the RAM window keeps written bytes
      if (addr < RAM_LIMIT)
         model[addr[12:2]] = merge_bytes(model[addr[12:2]], data, strb);
   endtask

   task automatic read_and_check(input logic [31:0] addr, input int delay);
      logic [31:0] data;
      logic [1:0]  resp;
      logic [31:0] exp_data;
      logic [1:0]  exp_resp;
      if (addr < RAM_LIMIT)
      begin
         exp_data = model[addr[12:2]];
         exp_resp = RESP_OKAY;
      end
      else if (addr == VERSION_REG)
      begin
         exp_data = VERSION_VAL;
         exp_resp = RESP_OKAY;
      end
      else
      begin
         exp_data = '0;
         exp_resp = RESP_SLVERR;
      end
      lite_read(addr, delay, data, resp);
      check_value(data, exp_data, $sformatf("rdata of read from %h", addr));
      check_value({30'd0, resp}, {30'd0, exp_resp}, $sformatf("rresp of read from %h", addr));
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors == errors_at_start)
      begin
         $display("Test %0d %s: passed", tests, name);
      end
      else
      begin
         tests_failed++;
         $display("Test %0d %s: failed, %0d errors", tests, name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   task automatic scrub_reads();
      for (int i = 0; i < 16; i++)
         read_and_check(ram_addr(), 0);
      finish_test("scrub");
   endtask

   task automatic lane_writes();
      logic [31:0] base;
      for (int i = 0; i < 24; i++)
      begin
         base = ram_addr() & ~32'h4;
         write_and_check(base, rand_bits(32), 4'hF, 0);
         write_and_check(base | 32'h4, rand_bits(32), 4'hF, 0);
         read_and_check(base, 0);
         read_and_check(base | 32'h4, 0);
         read_and_check(ram_addr(), 0);
      end
      finish_test("full words");
   endtask

   task automatic strobe_merges();
      logic [31:0] addr;
      for (int i = 0; i < 32; i++)
      begin
         addr = ram_addr();
         write_and_check(addr, rand_bits(32), 4'(rand_bits(4)), 0);
         read_and_check(addr, 0);
         // Other lane of the same RAM word
         read_and_check(addr ^ 32'h4, 0);
      end
      finish_test("strobes");
   endtask

   task automatic error_decode();
      logic [31:0] addr;
      read_and_check(VERSION_REG, 0);
      write_and_check(VERSION_REG, rand_bits(32), 4'hF, 0);
      read_and_check(VERSION_REG, 0);
      for (int i = 0; i < 8; i++)
      begin
         addr = high_addr();
         write_and_check(addr, rand_bits(32), 4'hF, 0);
         read_and_check(addr, 0);
      end
      for (int i = 0; i < 8; i++)
         read_and_check(ram_addr(), 0);
      finish_test("decode errors");
   endtask

   task automatic backpressure_mix();
      logic [31:0] addr;
      int          delay;
      for (int i = 0; i < 48; i++)
      begin
         delay = int'(rand_bits(3));
         addr  = (rand_bits(3) == 0) ? high_addr() : ram_addr();
         if (rand_bits(1) != 0)
            write_and_check(addr, rand_bits(32), 4'(rand_bits(4)), delay);
         else
            read_and_check(addr, delay);
      end
      @(posedge clk_main_a0);
      check_value(completed, issued, "completed Lite responses");
      finish_test("back-pressure");
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial
   begin
      rst_main_n <= 1'b0;
      awvalid    <= 1'b0;
      awaddr     <= '0;
      wvalid     <= 1'b0;
      wdata      <= '0;
      wstrb      <= '0;
      bready     <= 1'b0;
      arvalid    <= 1'b0;
      araddr     <= '0;
      rready     <= 1'b0;
      for (int i = 0; i < 2048; i++)
         model[i] = '0;
      repeat (8) @(posedge clk_main_a0);
      rst_main_n <= 1'b1;
      @(posedge clk_main_a0);

      scrub_reads();
      lane_writes();
      strobe_merges();
      error_decode();
      backpressure_mix();

      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tests, tests_failed, checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* tb_clock.sv */
module tb_clock
(
   output logic clk_main_a0
);

   // Free-running clock, period 8
   initial
   begin
      clk_main_a0 = 1'b0;
      forever
         #4 clk_main_a0 = ~clk_main_a0;
   end

endmodule
